/* hdl/matmul_macros.svh */
`ifndef MATMUL_MACROS_SVH
`define MATMUL_MACROS_SVH

// Array dimension and element widths
`define MAT_MUL_SIZE 4
`define DWIDTH 8
`define AWIDTH 10
`define STRIDE_WIDTH 8

// Cycles from a read address to its data on the memory port
`define MEM_ACCESS_LATENCY 1

// Operand register, product register, accumulator
`define NUM_CYCLES_IN_MAC 3

// The last product reaches PE(3,3) after the diagonal wavefront has crossed the array
`define LATCH_COUNT (3 * `MAT_MUL_SIZE - 1 + `NUM_CYCLES_IN_MAC)

// Done lines up with the last column leaving the drain
`define DONE_COUNT (`LATCH_COUNT + `MAT_MUL_SIZE)

`endif

/* hdl/matmul_pkg.sv */
`include "matmul_macros.svh"

package matmul_pkg;

    // One matrix element and one memory address
    typedef logic [`DWIDTH-1:0] data_t;
    typedef logic [`AWIDTH-1:0] addr_t;
    typedef logic [`STRIDE_WIDTH-1:0] stride_t;

    // Clock count of one multiplication
    typedef logic [7:0] cycle_t;

    // One bit per row, column or k index
    typedef logic [`MAT_MUL_SIZE-1:0] mask_t;

    // Four elements side by side, lane 0 in the low bits
    typedef logic [`MAT_MUL_SIZE*`DWIDTH-1:0] lane_vec_t;

    // Placement of one matrix in memory
    typedef struct packed {
        addr_t base;
        stride_t stride;
    } addr_cfg_t;

    typedef enum logic {
        DRAIN_IDLE,
        DRAIN_SHIFT
    } drain_state_t;

endpackage

/* hdl/processing_element.sv */
`timescale 1ns/1ps
`include "matmul_macros.svh"

module processing_element (
    input  logic              clk,
    input  logic              reset,
    input  matmul_pkg::data_t in_a,
    input  matmul_pkg::data_t in_b,
    output matmul_pkg::data_t out_a,
    output matmul_pkg::data_t out_b,
    output matmul_pkg::data_t out_c
);
    import matmul_pkg::*;

    data_t a_q;
    data_t b_q;
    data_t prod_q;
    data_t acc_q;

    ////////////////////////////////////////
    // Multiply-accumulate pipeline
    ////////////////////////////////////////

    // The operand registers double as the east and south pass-through
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            a_q <= '0;
            b_q <= '0;
            prod_q <= '0;
            acc_q <= '0;
        end
        else
        begin
            a_q <= in_a;
            b_q <= in_b;
            // Only the low byte of the product is kept
            prod_q <= data_t'(a_q * b_q);
            acc_q <= acc_q + prod_q;
        end
    end

    assign out_a = a_q;
    assign out_b = b_q;
    assign out_c = acc_q;

endmodule

/* hdl/pe_array.sv */
`timescale 1ns/1ps
`include "matmul_macros.svh"

module pe_array (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  pe_reset,
    input  matmul_pkg::lane_vec_t west_in,
    input  matmul_pkg::lane_vec_t north_in,
    output matmul_pkg::lane_vec_t results [`MAT_MUL_SIZE]
);
    import matmul_pkg::*;

    logic pe_clear;

    // Operand links; index MAT_MUL_SIZE is the far edge of the mesh
    data_t a_link [`MAT_MUL_SIZE][`MAT_MUL_SIZE+1];
    data_t b_link [`MAT_MUL_SIZE+1][`MAT_MUL_SIZE];
    data_t acc [`MAT_MUL_SIZE][`MAT_MUL_SIZE];

    // Accumulators clear on a full reset or between products
    assign pe_clear = reset | pe_reset;

    ////////////////////////////////////////
    // Edge feeds
    ////////////////////////////////////////

    for (genvar n = 0; n < `MAT_MUL_SIZE; n++)
    begin : g_edge
        assign a_link[n][0] = west_in[n*`DWIDTH +: `DWIDTH];
        assign b_link[0][n] = north_in[n*`DWIDTH +: `DWIDTH];
    end

    ////////////////////////////////////////
    // Mesh
    ////////////////////////////////////////

    // PE(i,j) takes A from the west and B from the north
    for (genvar i = 0; i < `MAT_MUL_SIZE; i++)
    begin : g_row
        for (genvar j = 0; j < `MAT_MUL_SIZE; j++)
        begin : g_col
            processing_element pe_inst (
                .clk   (clk),
                .reset (pe_clear),
                .in_a  (a_link[i][j]),
                .in_b  (b_link[i][j]),
                .out_a (a_link[i][j+1]),
                .out_b (b_link[i+1][j]),
                .out_c (acc[i][j])
            );

            // Column j of C, row i in lane i
            assign results[j][i*`DWIDTH +: `DWIDTH] = acc[i][j];
        end
    end

endmodule

/* hdl/matmul_sequencer.sv */
`timescale 1ns/1ps
`include "matmul_macros.svh"

module matmul_sequencer (
    input  logic               clk,
    input  logic               reset,
    input  logic               start_mat_mul,
    output matmul_pkg::cycle_t clk_cnt,
    output logic               done_mat_mul
);
    import matmul_pkg::*;

    cycle_t cnt_next;

    // The count saturates so that done cannot fire a second time while start is held
    assign cnt_next = (clk_cnt == '1) ? clk_cnt : clk_cnt + 1'b1;

    ////////////////////////////////////////
    // Clock count and done pulse
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
        begin
            clk_cnt <= '0;
            done_mat_mul <= 1'b0;
        end
        else
        begin
            clk_cnt <= cnt_next;
            // High in the one cycle where the count reads DONE_COUNT
            done_mat_mul <= (cnt_next == cycle_t'(`DONE_COUNT));
        end
    end

endmodule

/* hdl/operand_feeder.sv */
`timescale 1ns/1ps
`include "matmul_macros.svh"

module operand_feeder (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start_mat_mul,
    input  matmul_pkg::cycle_t    clk_cnt,
    input  matmul_pkg::addr_cfg_t cfg,
    input  matmul_pkg::lane_vec_t mem_data,
    input  matmul_pkg::mask_t     lane_mask,
    input  matmul_pkg::mask_t     k_mask,
    output matmul_pkg::addr_t     mem_addr,
    output matmul_pkg::lane_vec_t skewed
);
    import matmul_pkg::*;

    addr_t stride_ext;
    logic mem_access;
    logic [2:0] access_cnt;
    logic k_blocked;
    logic data_valid;
    data_t qualified [`MAT_MUL_SIZE];

    assign stride_ext = addr_t'(cfg.stride);

    ////////////////////////////////////////
    // Read address stepping
    ////////////////////////////////////////

    // The address idles one stride below the base so the first step lands on it
    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul || clk_cnt >= cycle_t'(`MAT_MUL_SIZE))
        begin
            mem_addr <= cfg.base - stride_ext;
            mem_access <= 1'b0;
        end
        else
        begin
            mem_addr <= mem_addr + stride_ext;
            mem_access <= 1'b1;
        end
    end

    // Counts cycles since the first address went out
    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul || !mem_access)
            access_cnt <= '0;
        else
            access_cnt <= access_cnt + 1'b1;
    end

    ////////////////////////////////////////
    // Valid window and masking
    ////////////////////////////////////////

    // Word n of the matrix arrives while the counter reads n+1
    always_comb
    begin
        k_blocked = 1'b0;
        for (int n = 0; n < `MAT_MUL_SIZE; n++)
        begin
            if (access_cnt == 3'(n + 1) && !k_mask[n])
                k_blocked = 1'b1;
        end
    end

    assign data_valid = !k_blocked && (access_cnt >= 3'(`MEM_ACCESS_LATENCY));

    always_comb
    begin
        for (int n = 0; n < `MAT_MUL_SIZE; n++)
        begin
            if (data_valid && lane_mask[n])
                qualified[n] = mem_data[n*`DWIDTH +: `DWIDTH];
            else
                qualified[n] = '0;
        end
    end

    ////////////////////////////////////////
    // Lane skew
    ////////////////////////////////////////

    for (genvar n = 0; n < `MAT_MUL_SIZE; n++)
    begin : g_lane
        if (n == 0)
        begin : g_direct
            assign skewed[n*`DWIDTH +: `DWIDTH] = qualified[n];
        end
        else
        begin : g_delay
            // Lane n waits n cycles so the array sees a diagonal wavefront
            data_t stage [n];

            always_ff @(posedge clk)
            begin
                if (reset || !start_mat_mul || clk_cnt == '0)
                begin
                    for (int s = 0; s < n; s++)
                        stage[s] <= '0;
                end
                else
                begin
                    stage[0] <= qualified[n];
                    for (int s = 1; s < n; s++)
                        stage[s] <= stage[s-1];
                end
            end

            assign skewed[n*`DWIDTH +: `DWIDTH] = stage[n-1];
        end
    end

endmodule

/* hdl/result_drain.sv */
`timescale 1ns/1ps
`include "matmul_macros.svh"

module result_drain (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start_mat_mul,
    input  logic                  done_mat_mul,
    input  matmul_pkg::cycle_t    clk_cnt,
    input  matmul_pkg::addr_cfg_t cfg,
    input  matmul_pkg::lane_vec_t results [`MAT_MUL_SIZE],
    output matmul_pkg::lane_vec_t c_data_out,
    output matmul_pkg::addr_t     c_addr,
    output logic                  c_data_available
);
    import matmul_pkg::*;

    drain_state_t state;
    addr_t stride_ext;
    logic latch_en;

    // Columns 1 to 3 wait here while column 0 is on the output
    lane_vec_t pending [`MAT_MUL_SIZE-1];

    assign stride_ext = addr_t'(cfg.stride);
    assign latch_en = (clk_cnt == cycle_t'(`LATCH_COUNT));

    ////////////////////////////////////////
    // Latch and shift
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
        begin
            state <= DRAIN_IDLE;
            c_data_available <= 1'b0;
            c_addr <= cfg.base - stride_ext;
            c_data_out <= '0;
            for (int n = 0; n < `MAT_MUL_SIZE - 1; n++)
                pending[n] <= '0;
        end
        else if (latch_en)
        begin
            // All accumulators are final by now
            state <= DRAIN_SHIFT;
            c_data_available <= 1'b1;
            c_addr <= cfg.base;
            c_data_out <= results[0];
            for (int n = 0; n < `MAT_MUL_SIZE - 1; n++)
                pending[n] <= results[n+1];
        end
        else if (done_mat_mul)
        begin
            // Done shares its cycle with the last column
            state <= DRAIN_IDLE;
            c_data_available <= 1'b0;
            c_addr <= cfg.base - stride_ext;
            c_data_out <= '0;
            for (int n = 0; n < `MAT_MUL_SIZE - 1; n++)
                pending[n] <= '0;
        end
        else if (state == DRAIN_SHIFT)
        begin
            c_addr <= c_addr + stride_ext;
            c_data_out <= pending[0];
            for (int n = 0; n < `MAT_MUL_SIZE - 2; n++)
                pending[n] <= pending[n+1];
            pending[`MAT_MUL_SIZE-2] <= '0;
        end
    end

endmodule

/* hdl/matmul_systolic_top.sv */
`timescale 1ns/1ps
`include "matmul_macros.svh"

module matmul_systolic_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  pe_reset,
    input  logic                  start_mat_mul,
    input  matmul_pkg::addr_cfg_t cfg_a,
    input  matmul_pkg::addr_cfg_t cfg_b,
    input  matmul_pkg::addr_cfg_t cfg_c,
    input  matmul_pkg::lane_vec_t a_data,
    input  matmul_pkg::lane_vec_t b_data,
    input  matmul_pkg::mask_t     validity_mask_a_rows,
    input  matmul_pkg::mask_t     validity_mask_a_cols_b_rows,
    input  matmul_pkg::mask_t     validity_mask_b_cols,
    output matmul_pkg::addr_t     a_addr,
    output matmul_pkg::addr_t     b_addr,
    output matmul_pkg::addr_t     c_addr,
    output matmul_pkg::lane_vec_t c_data_out,
    output logic                  c_data_available,
    output logic                  done_mat_mul
);
    import matmul_pkg::*;

    cycle_t clk_cnt;
    lane_vec_t west_edge;
    lane_vec_t north_edge;
    lane_vec_t col_results [`MAT_MUL_SIZE];

    matmul_sequencer sequencer_inst (
        .clk           (clk),
        .reset         (reset),
        .start_mat_mul (start_mat_mul),
        .clk_cnt       (clk_cnt),
        .done_mat_mul  (done_mat_mul)
    );

    ////////////////////////////////////////
    // Operand feeders
    ////////////////////////////////////////

    // A rows enter from the west, one lane per array row
    operand_feeder a_feeder (
        .clk           (clk),
        .reset         (reset),
        .start_mat_mul (start_mat_mul),
        .clk_cnt       (clk_cnt),
        .cfg           (cfg_a),
        .mem_data      (a_data),
        .lane_mask     (validity_mask_a_rows),
        .k_mask        (validity_mask_a_cols_b_rows),
        .mem_addr      (a_addr),
        .skewed        (west_edge)
    );

    // B columns enter from the north
    operand_feeder b_feeder (
        .clk           (clk),
        .reset         (reset),
        .start_mat_mul (start_mat_mul),
        .clk_cnt       (clk_cnt),
        .cfg           (cfg_b),
        .mem_data      (b_data),
        .lane_mask     (validity_mask_b_cols),
        .k_mask        (validity_mask_a_cols_b_rows),
        .mem_addr      (b_addr),
        .skewed        (north_edge)
    );

    ////////////////////////////////////////
    // Array and drain
    ////////////////////////////////////////

    pe_array pe_array_inst (
        .clk      (clk),
        .reset    (reset),
        .pe_reset (pe_reset),
        .west_in  (west_edge),
        .north_in (north_edge),
        .results  (col_results)
    );

    result_drain drain_inst (
        .clk              (clk),
        .reset            (reset),
        .start_mat_mul    (start_mat_mul),
        .done_mat_mul     (done_mat_mul),
        .clk_cnt          (clk_cnt),
        .cfg              (cfg_c),
        .results          (col_results),
        .c_data_out       (c_data_out),
        .c_addr           (c_addr),
        .c_data_available (c_data_available)
    );

endmodule

/* testbench/matmul_tb.sv */
`timescale 1ns/1ps
`include "matmul_macros.svh"

module matmul_tb;
    import matmul_pkg::*;

    localparam int MEM_DEPTH = 1 << `AWIDTH;
    localparam int RUN_TIMEOUT = 40;

    logic clk;
    logic reset;
    logic pe_reset;
    logic start_mat_mul;
    addr_cfg_t cfg_a;
    addr_cfg_t cfg_b;
    addr_cfg_t cfg_c;
    lane_vec_t a_data;
    lane_vec_t b_data;
    mask_t mask_rows;
    mask_t mask_k;
    mask_t mask_cols;
    addr_t a_addr;
    addr_t b_addr;
    addr_t c_addr;
    lane_vec_t c_data_out;
    logic c_data_available;
    logic done_mat_mul;

    lane_vec_t mem_a [MEM_DEPTH];
    lane_vec_t mem_b [MEM_DEPTH];
    lane_vec_t expected_cols [`MAT_MUL_SIZE];
    addr_t a_read_addr;
    addr_t b_read_addr;
    logic [31:0] rng_state;
    int value_errors;
    int other_errors;
    logic timed_out;

    matmul_systolic_top matmul_systolic_top_inst (
        .clk                         (clk),
        .reset                       (reset),
        .pe_reset                    (pe_reset),
        .start_mat_mul               (start_mat_mul),
        .cfg_a                       (cfg_a),
        .cfg_b                       (cfg_b),
        .cfg_c                       (cfg_c),
        .a_data                      (a_data),
        .b_data                      (b_data),
        .validity_mask_a_rows        (mask_rows),
        .validity_mask_a_cols_b_rows (mask_k),
        .validity_mask_b_cols        (mask_cols),
        .a_addr                      (a_addr),
        .b_addr                      (b_addr),
        .c_addr                      (c_addr),
        .c_data_out                  (c_data_out),
        .c_data_available            (c_data_available),
        .done_mat_mul                (done_mat_mul)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////
    // Synchronous A and B memories
    ////////////////////////////////////////

    // An address seen in one cycle shows its word after the next rising edge
    initial
    begin
        a_data = '0;
        b_data = '0;
        forever
        begin
            @(negedge clk);
            a_read_addr = a_addr;
            b_read_addr = b_addr;
            @(posedge clk);
            #1;
            a_data = mem_a[a_read_addr];
            b_data = mem_b[b_read_addr];
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // The upper halves of two steps, since the low LCG bits repeat quickly
    task automatic fill_memories();
        logic [31:0] first;
        for (int addr = 0; addr < MEM_DEPTH; addr++)
        begin
            rng_state = lcg_next(rng_state);
            first = rng_state;
            rng_state = lcg_next(rng_state);
            mem_a[addr] = {first[31:16], rng_state[31:16]};
            rng_state = lcg_next(rng_state);
            first = rng_state;
            rng_state = lcg_next(rng_state);
            mem_b[addr] = {first[31:16], rng_state[31:16]};
        end
    endtask

    function automatic addr_cfg_t make_cfg(input addr_t base, input stride_t stride);
        addr_cfg_t cfg;
        cfg.base = base;
        cfg.stride = stride;
        return cfg;
    endfunction

    // Address of row r of a matrix placed by cfg
    function automatic addr_t word_addr(input addr_cfg_t cfg, input int r);
        return cfg.base + addr_t'(r) * addr_t'(cfg.stride);
    endfunction

    ////////////////////////////////////////
    // Reference model and checks
    ////////////////////////////////////////

    // Word k of A holds column k of A, word k of B holds row k of B
    task automatic compute_expected(input addr_cfg_t ca, input addr_cfg_t cb,
                                    input mask_t rows, input mask_t ks, input mask_t cols);
        lane_vec_t a_word;
        lane_vec_t b_word;
        data_t a_el;
        data_t b_el;
        data_t sum;
        for (int j = 0; j < `MAT_MUL_SIZE; j++)
        begin
            for (int i = 0; i < `MAT_MUL_SIZE; i++)
            begin
                sum = '0;
                for (int k = 0; k < `MAT_MUL_SIZE; k++)
                begin
                    a_word = mem_a[word_addr(ca, k)];
                    b_word = mem_b[word_addr(cb, k)];
                    a_el = a_word[i*`DWIDTH +: `DWIDTH];
                    b_el = b_word[j*`DWIDTH +: `DWIDTH];
                    if (ks[k] && rows[i] && cols[j])
                        sum = sum + a_el * b_el;
                end
                expected_cols[j][i*`DWIDTH +: `DWIDTH] = sum;
            end
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual == expected)
        else
        begin
            value_errors++;
            $display("Error at %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond)
        else
        begin
            other_errors++;
            $display("Failure at %0t: %s", $time, what);
        end
    endtask

    ////////////////////////////////////////
    // One multiplication
    ////////////////////////////////////////

    task automatic run_product(input addr_cfg_t ca, input addr_cfg_t cb, input addr_cfg_t cc,
                               input mask_t rows, input mask_t ks, input mask_t cols);
        int cycle;
        int col;
        logic seen_done;
        compute_expected(ca, cb, rows, ks, cols);
        @(posedge clk);
        #1;
        cfg_a = ca;
        cfg_b = cb;
        cfg_c = cc;
        mask_rows = rows;
        mask_k = ks;
        mask_cols = cols;
        pe_reset = 1'b1;
        @(posedge clk);
        #1;
        pe_reset = 1'b0;
        start_mat_mul = 1'b1;
        cycle = 0;
        col = 0;
        seen_done = 1'b0;
        while (!seen_done && cycle < RUN_TIMEOUT)
        begin
            @(posedge clk);
            cycle++;
            @(negedge clk);
            // Rows 0 to 3 go out on the first four edges
            if (cycle <= `MAT_MUL_SIZE)
            begin
                check_value("a_addr", 32'(word_addr(ca, cycle - 1)), 32'(a_addr));
                check_value("b_addr", 32'(word_addr(cb, cycle - 1)), 32'(b_addr));
            end
            if (c_data_available)
            begin
                check_true(col < `MAT_MUL_SIZE, "c_data_available was high for over four cycles");
                if (col < `MAT_MUL_SIZE)
                begin
                    check_value("c_addr", 32'(word_addr(cc, col)), 32'(c_addr));
                    for (int i = 0; i < `MAT_MUL_SIZE; i++)
                        check_value($sformatf("c_data_out col %0d lane %0d", col, i),
                                    32'(expected_cols[col][i*`DWIDTH +: `DWIDTH]),
                                    32'(c_data_out[i*`DWIDTH +: `DWIDTH]));
                end
                col++;
            end
            if (done_mat_mul)
            begin
                seen_done = 1'b1;
                check_true(c_data_available && col == `MAT_MUL_SIZE,
                           "done_mat_mul did not fall in the fourth cycle of C output");
            end
        end
        if (!seen_done)
        begin
            other_errors++;
            timed_out = 1'b1;
            $display("Timeout: done_mat_mul did not rise within %0d cycles", RUN_TIMEOUT);
        end
        else
        begin
            @(posedge clk);
            @(negedge clk);
            check_true(!done_mat_mul, "done_mat_mul was high for more than one cycle");
            check_true(!c_data_available, "c_data_available stayed high after done");
            @(posedge clk);
            #1;
            start_mat_mul = 1'b0;
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial
    begin
        reset = 1'b1;
        pe_reset = 1'b0;
        start_mat_mul = 1'b0;
        cfg_a = make_cfg(10'h010, 8'h04);
        cfg_b = make_cfg(10'h200, 8'h03);
        cfg_c = make_cfg(10'h300, 8'h08);
        mask_rows = 4'b1111;
        mask_k = 4'b1111;
        mask_cols = 4'b1111;
        value_errors = 0;
        other_errors = 0;
        timed_out = 1'b0;
        rng_state = 32'h2e45;
        fill_memories();
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        // Idle after reset, addresses one stride below their bases
        @(negedge clk);
        check_true(!done_mat_mul, "done_mat_mul was high after reset");
        check_true(!c_data_available, "c_data_available was high after reset");
        check_value("a_addr", 32'(cfg_a.base - addr_t'(cfg_a.stride)), 32'(a_addr));
        check_value("b_addr", 32'(cfg_b.base - addr_t'(cfg_b.stride)), 32'(b_addr));
        check_value("c_addr", 32'(cfg_c.base - addr_t'(cfg_c.stride)), 32'(c_addr));

        run_product(make_cfg(10'h010, 8'h04), make_cfg(10'h200, 8'h03),
                    make_cfg(10'h300, 8'h08), 4'b1111, 4'b1111, 4'b1111);
        if (!timed_out)
            run_product(make_cfg(10'h3f0, 8'h05), make_cfg(10'h0c4, 8'h10),
                        make_cfg(10'h180, 8'h02), 4'b1011, 4'b0110, 4'b1101);
        // Back to back with new data, so stale accumulators would show
        if (!timed_out)
            run_product(make_cfg(10'h123, 8'h11), make_cfg(10'h0a7, 8'h02),
                        make_cfg(10'h055, 8'h01), 4'b1111, 4'b1111, 4'b1111);
        if (!timed_out)
            run_product(make_cfg(10'h2a0, 8'h07), make_cfg(10'h381, 8'h09),
                        make_cfg(10'h001, 8'h04), 4'b0111, 4'b1001, 4'b0010);

        $display("Summary: %0d value errors, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

/* sources.f */
+incdir+hdl
hdl/matmul_pkg.sv
hdl/processing_element.sv
hdl/pe_array.sv
hdl/matmul_sequencer.sv
hdl/operand_feeder.sv
hdl/result_drain.sv
hdl/matmul_systolic_top.sv
testbench/matmul_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module matmul_tb \
    -f sources.f -o matmul_sim \
    && ./obj_dir/matmul_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "All checks passed" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
